//--- hdl/ram_pkg.sv
// Shared widths and vector types for the 68000 byte-lane state RAM
`default_nettype none

package ram_pkg;

    // ==============================
    // Widths
    // ==============================

    // CPU word, split into byte lanes
    localparam int DATA_WIDTH = 16;
    localparam int LANE_WIDTH = 8;
    localparam int LANE_COUNT = DATA_WIDTH / LANE_WIDTH;

    // Save-state bus is wider than the RAM word
    localparam int SS_DATA_WIDTH = 64;

    // ==============================
    // Types
    // ==============================

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // Bit 1 upper lane, bit 0 lower lane, high means write
    typedef logic [LANE_COUNT-1:0] lane_mask_t;

    // Read responses carry the word in the low bits
    typedef logic [SS_DATA_WIDTH-1:0] ss_data_t;

endpackage

`default_nettype wire

//--- hdl/ss_request_decode.sv
// Save-state request queue and RAM port arbitration between save-state and CPU
`default_nettype none

module ss_request_decode #(
    parameter int ADDR_WIDTH = 10,
    parameter int SS_CREDITS = 2
) (
    input  wire                     clock,
    input  wire                     rst,

    // CPU side
    input  wire [ADDR_WIDTH-1:0]    address,
    input  wire ram_pkg::word_t     data,
    input  wire                     we_uds_n,
    input  wire                     we_lds_n,

    // Save-state requests, credited
    input  wire                     ss_req_valid,
    input  wire                     ss_req_write,
    input  wire [ADDR_WIDTH-1:0]    ss_req_addr,
    input  wire ram_pkg::ss_data_t  ss_req_data,

    // RAM port
    output logic [ADDR_WIDTH-1:0]   ram_addr,
    output ram_pkg::word_t          ram_data,
    output ram_pkg::lane_mask_t     ram_lanes,
    output logic                    ss_exec,
    output logic                    ss_exec_write
);

    localparam int PTR_WIDTH = (SS_CREDITS > 1) ? $clog2(SS_CREDITS) : 1;
    localparam int CNT_WIDTH = $clog2(SS_CREDITS + 1);

    // Queue payload
    logic [ADDR_WIDTH-1:0] q_addr [SS_CREDITS];
    ram_pkg::word_t        q_data [SS_CREDITS];
    logic                  q_write [SS_CREDITS];

    logic [PTR_WIDTH-1:0]  wr_ptr;
    logic [PTR_WIDTH-1:0]  rd_ptr;
    logic [CNT_WIDTH-1:0]  count;
    logic                  push;
    logic                  pop;

    // Popped last cycle, its credit not yet back at the requester
    logic                  popped;

    // Circular pointer step, wraps at queue depth
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        if (ptr == PTR_WIDTH'(SS_CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ==============================
    // Request queue
    // ==============================

    assign push = ss_req_valid;
    assign pop  = (count != '0);

    always_ff @(posedge clock) begin
        if (push) begin
            q_addr[wr_ptr]  <= ss_req_addr;
            q_data[wr_ptr]  <= ss_req_data[ram_pkg::DATA_WIDTH-1:0];
            q_write[wr_ptr] <= ss_req_write;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            popped <= 1'b0;
        end else begin
            popped <= pop;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // ==============================
    // Port steering
    // ==============================

    // Oldest queued request owns the RAM for one cycle
    assign ss_exec       = pop;
    assign ss_exec_write = pop && q_write[rd_ptr];

    assign ram_addr = ss_exec ? q_addr[rd_ptr] : address;
    assign ram_data = ss_exec ? q_data[rd_ptr] : data;

    // Save-state write takes both lanes, a read none; CPU enables are active low
    assign ram_lanes = ss_exec ? (ss_exec_write ? '1 : '0) : {~we_uds_n, ~we_lds_n};

    // Queued and just popped requests still hold the requester's credits
    a_push_with_credit: assert property (
        @(posedge clock) disable iff (rst)
        ss_req_valid |-> ((count + CNT_WIDTH'(popped)) < CNT_WIDTH'(SS_CREDITS))
    ) else $error("save-state request sent without a credit");

endmodule

`default_nettype wire

//--- hdl/byte_lane_ram.sv
// Byte-lane RAM with per-lane writes and registered write-through read
`default_nettype none

module byte_lane_ram #(
    parameter int ADDR_WIDTH = 10
) (
    input  wire                       clock,
    input  wire                       rst,
    input  wire [ADDR_WIDTH-1:0]      ram_addr,
    input  wire ram_pkg::word_t       ram_data,
    input  wire ram_pkg::lane_mask_t  ram_lanes,
    output ram_pkg::word_t            rd_data
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Lane 1 lands in the upper byte of rd_data
    ram_pkg::lane_t [ram_pkg::LANE_COUNT-1:0] rd_lanes;

    assign rd_data = rd_lanes;

    // ==============================
    // One array per byte lane
    // ==============================

    for (genvar i = 0; i < ram_pkg::LANE_COUNT; i++) begin : g_lane

        ram_pkg::lane_t mem [DEPTH];
        ram_pkg::lane_t wr_byte;

        assign wr_byte = ram_data[i*ram_pkg::LANE_WIDTH +: ram_pkg::LANE_WIDTH];

        always_ff @(posedge clock) begin
            if (ram_lanes[i]) begin
                mem[ram_addr] <= wr_byte;
            end
        end

        // New byte on a written lane, stored byte otherwise
        always_ff @(posedge clock) begin
            if (rst) begin
                rd_lanes[i] <= '0;
            end else if (ram_lanes[i]) begin
                rd_lanes[i] <= wr_byte;
            end else begin
                rd_lanes[i] <= mem[ram_addr];
            end
        end

    end

    // Lane enables come from the CPU pins or the save-state queue
    a_lanes_known: assert property (
        @(posedge clock) disable iff (rst)
        !$isunknown(ram_lanes)
    ) else $error("byte lane enables unknown");

endmodule

`default_nettype wire

//--- hdl/ss_response.sv
// Save-state response register and request credit return
`default_nettype none

module ss_response (
    input  wire                     clock,
    input  wire                     rst,

    // Operation executed on the RAM this cycle
    input  wire                     ss_exec,
    input  wire                     ss_exec_write,

    // Registered RAM word, valid the cycle after execution
    input  wire ram_pkg::word_t     rd_data,

    output logic                    ss_rsp_valid,
    output logic                    ss_rsp_write,
    output ram_pkg::ss_data_t       ss_rsp_data,
    output logic                    ss_req_credit
);

    localparam int PAD_WIDTH = ram_pkg::SS_DATA_WIDTH - ram_pkg::DATA_WIDTH;

    // ==============================
    // Response flags
    // ==============================

    always_ff @(posedge clock) begin
        if (rst) begin
            ss_rsp_valid <= 1'b0;
            ss_rsp_write <= 1'b0;
        end else begin
            ss_rsp_valid <= ss_exec;
            ss_rsp_write <= ss_exec_write;
        end
    end

    // Queue slot is free once the RAM has taken the request
    always_ff @(posedge clock) begin
        if (rst) begin
            ss_req_credit <= 1'b0;
        end else begin
            ss_req_credit <= ss_exec;
        end
    end

    // ==============================
    // Response data
    // ==============================

    // Write acks carry zero; rd_data holds write-through data then
    assign ss_rsp_data = (ss_rsp_valid && !ss_rsp_write) ?
                         {{PAD_WIDTH{1'b0}}, rd_data} : '0;

    // Write flag only comes with an executed operation
    a_write_needs_exec: assert property (
        @(posedge clock) disable iff (rst)
        ss_exec_write |-> ss_exec
    ) else $error("save-state write flag without an executed operation");

endmodule

`default_nettype wire

//--- hdl/m68k_state_ram.sv
// 68000 byte-lane RAM with a credited save-state port, top level
`default_nettype none

module m68k_state_ram #(
    parameter int ADDR_WIDTH = 10,
    parameter int SS_CREDITS = 2
) (
    input  wire                     clock,
    input  wire                     rst,

    // CPU port
    input  wire [ADDR_WIDTH-1:0]    address,
    input  wire ram_pkg::word_t     data,
    input  wire                     we_uds_n,
    input  wire                     we_lds_n,
    output wire ram_pkg::word_t     q,

    // Save-state requests
    input  wire                     ss_req_valid,
    input  wire                     ss_req_write,
    input  wire [ADDR_WIDTH-1:0]    ss_req_addr,
    input  wire ram_pkg::ss_data_t  ss_req_data,
    output wire                     ss_req_credit,

    // Save-state responses
    output wire                     ss_rsp_valid,
    output wire                     ss_rsp_write,
    output wire ram_pkg::ss_data_t  ss_rsp_data
);

    wire [ADDR_WIDTH-1:0]       ram_addr;
    wire ram_pkg::word_t        ram_data;
    wire ram_pkg::lane_mask_t   ram_lanes;
    wire                        ss_exec;
    wire                        ss_exec_write;

    ss_request_decode #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .SS_CREDITS(SS_CREDITS)
    ) u_decode (
        .clock(clock),
        .rst(rst),
        .address(address),
        .data(data),
        .we_uds_n(we_uds_n),
        .we_lds_n(we_lds_n),
        .ss_req_valid(ss_req_valid),
        .ss_req_write(ss_req_write),
        .ss_req_addr(ss_req_addr),
        .ss_req_data(ss_req_data),
        .ram_addr(ram_addr),
        .ram_data(ram_data),
        .ram_lanes(ram_lanes),
        .ss_exec(ss_exec),
        .ss_exec_write(ss_exec_write)
    );

    byte_lane_ram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_ram (
        .clock(clock),
        .rst(rst),
        .ram_addr(ram_addr),
        .ram_data(ram_data),
        .ram_lanes(ram_lanes),
        .rd_data(q)
    );

    // Read responses take the same registered word as the CPU
    ss_response u_response (
        .clock(clock),
        .rst(rst),
        .ss_exec(ss_exec),
        .ss_exec_write(ss_exec_write),
        .rd_data(q),
        .ss_rsp_valid(ss_rsp_valid),
        .ss_rsp_write(ss_rsp_write),
        .ss_rsp_data(ss_rsp_data),
        .ss_req_credit(ss_req_credit)
    );

endmodule

`default_nettype wire

//--- test/tb_m68k_state_ram.sv
// Testbench for the 68000 byte-lane state RAM, CPU port and credited save-state port
`default_nettype none

module tb_m68k_state_ram;

    localparam int ADDR_WIDTH   = 10;
    localparam int SS_CREDITS   = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;

    // Tests stay in a small address window, every word written first
    localparam int                    POOL_SIZE = 32;
    localparam logic [ADDR_WIDTH-1:0] POOL_BASE = 10'h140;

    // Full sequence takes roughly 450 cycles
    localparam int MAX_CYCLES = 3000;

    typedef logic [$clog2(POOL_SIZE)-1:0] idx_t;

    logic                   clock;
    logic                   rst;
    logic [ADDR_WIDTH-1:0]  address;
    ram_pkg::word_t         data;
    logic                   we_uds_n;
    logic                   we_lds_n;
    ram_pkg::word_t         q;
    logic                   ss_req_valid;
    logic                   ss_req_write;
    logic [ADDR_WIDTH-1:0]  ss_req_addr;
    ram_pkg::ss_data_t      ss_req_data;
    logic                   ss_req_credit;
    logic                   ss_rsp_valid;
    logic                   ss_rsp_write;
    ram_pkg::ss_data_t      ss_rsp_data;

    int    seed = 20577;
    int    cycle_count = 0;
    string test_name = "reset";

    // Reference model
    ram_pkg::word_t    model_mem [POOL_SIZE];
    ram_pkg::ss_data_t rsp_data_q [$];
    logic              rsp_write_q [$];

    // Expected q, set with the stimulus and registered beside the DUT
    ram_pkg::word_t next_exp_q = '0;
    logic           next_chk_q = 1'b0;
    ram_pkg::word_t exp_q = '0;
    logic           chk_q = 1'b0;

    // Oldest response still owed
    ram_pkg::ss_data_t exp_rsp_data = '0;
    logic              exp_rsp_write = 1'b0;
    logic              rsp_expected = 1'b0;

    int reqs_sent = 0;
    int credits_back = 0;
    int max_outstanding = 0;

    m68k_state_ram #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .SS_CREDITS(SS_CREDITS)
    ) DUT (
        .clock(clock),
        .rst(rst),
        .address(address),
        .data(data),
        .we_uds_n(we_uds_n),
        .we_lds_n(we_lds_n),
        .q(q),
        .ss_req_valid(ss_req_valid),
        .ss_req_write(ss_req_write),
        .ss_req_addr(ss_req_addr),
        .ss_req_data(ss_req_data),
        .ss_req_credit(ss_req_credit),
        .ss_rsp_valid(ss_rsp_valid),
        .ss_rsp_write(ss_rsp_write),
        .ss_rsp_data(ss_rsp_data)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // ==============================
    // Error reporting
    // ==============================

    task automatic stop_failed();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input ram_pkg::ss_data_t expected,
                               input ram_pkg::ss_data_t actual);
        $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
        stop_failed();
    endtask

    task automatic flow_error(input string what);
        $display("%s", what);
        stop_failed();
    endtask

    // ==============================
    // Model bookkeeping
    // ==============================

    always @(posedge clock) begin
        exp_q <= next_exp_q;
        chk_q <= next_chk_q;
    end

    always @(posedge clock) begin
        if (ss_req_credit) begin
            credits_back <= credits_back + 1;
        end
        if (ss_rsp_valid && rsp_data_q.size() != 0) begin
            void'(rsp_data_q.pop_front());
            void'(rsp_write_q.pop_front());
        end
        if (rsp_data_q.size() != 0) begin
            exp_rsp_data  <= rsp_data_q[0];
            exp_rsp_write <= rsp_write_q[0];
            rsp_expected  <= 1'b1;
        end else begin
            rsp_expected  <= 1'b0;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            flow_error("Timeout, the run went past its cycle limit");
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_q_model: assert property (@(posedge clock) disable iff (rst) chk_q |-> (q == exp_q))
        else value_error(test_name, ram_pkg::ss_data_t'($sampled(exp_q)),
                         ram_pkg::ss_data_t'($sampled(q)));

    a_quiet_before_use: assert property (@(posedge clock) disable iff (rst)
        (reqs_sent == 0) |-> (!ss_rsp_valid && !ss_req_credit))
        else flow_error("Response or credit seen before any save-state request");

    a_rsp_owed: assert property (@(posedge clock) disable iff (rst)
        ss_rsp_valid |-> rsp_expected)
        else flow_error("Save-state response arrived with no request outstanding");

    a_rsp_kind: assert property (@(posedge clock) disable iff (rst)
        ss_rsp_valid |-> (ss_rsp_write == exp_rsp_write))
        else value_error(test_name, ram_pkg::ss_data_t'($sampled(exp_rsp_write)),
                         ram_pkg::ss_data_t'($sampled(ss_rsp_write)));

    a_rsp_data: assert property (@(posedge clock) disable iff (rst)
        ss_rsp_valid |-> (ss_rsp_data == exp_rsp_data))
        else value_error(test_name, $sampled(exp_rsp_data), $sampled(ss_rsp_data));

    a_credit_budget: assert property (@(posedge clock) disable iff (rst)
        ((reqs_sent - credits_back) <= SS_CREDITS) && (credits_back <= reqs_sent))
        else flow_error("Returned credits do not match the requests sent");

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic drive_quiet();
        we_uds_n     = 1'b1;
        we_lds_n     = 1'b1;
        ss_req_valid = 1'b0;
        next_chk_q   = 1'b0;
    endtask

    task automatic idle_cycle();
        drive_quiet();
        next_cycle();
    endtask

    // Lets pending checks finish before the test name moves on
    task automatic settle();
        repeat (2) idle_cycle();
    endtask

    task automatic cpu_write(input idx_t idx, input ram_pkg::word_t wdata,
                             input logic uds_n, input logic lds_n);
        ram_pkg::word_t merged;
        merged = model_mem[idx];
        // Upper lane
        if (!uds_n) begin
            merged[15:8] = wdata[15:8];
        end
        if (!lds_n) begin
            merged[7:0] = wdata[7:0];
        end
        model_mem[idx] = merged;
        drive_quiet();
        address    = POOL_BASE + ADDR_WIDTH'(idx);
        data       = wdata;
        we_uds_n   = uds_n;
        we_lds_n   = lds_n;
        next_exp_q = merged;
        next_chk_q = 1'b1;
        next_cycle();
    endtask

    task automatic cpu_read(input idx_t idx);
        drive_quiet();
        address    = POOL_BASE + ADDR_WIDTH'(idx);
        next_exp_q = model_mem[idx];
        next_chk_q = 1'b1;
        next_cycle();
    endtask

    task automatic read_all();
        for (int i = 0; i < POOL_SIZE; i++) begin
            cpu_read(idx_t'(i));
        end
    endtask

    task automatic ss_send(input logic write, input idx_t idx, input ram_pkg::word_t wdata);
        ram_pkg::ss_data_t bus;
        while ((reqs_sent - credits_back) >= SS_CREDITS) begin
            idle_cycle();
        end
        // Upper bits are noise the RAM has to ignore
        bus = {$random(seed), $random(seed)};
        bus[ram_pkg::DATA_WIDTH-1:0] = wdata;
        if (write) begin
            model_mem[idx] = wdata;
            rsp_data_q.push_back(ram_pkg::ss_data_t'(0));
        end else begin
            rsp_data_q.push_back(ram_pkg::ss_data_t'(model_mem[idx]));
        end
        rsp_write_q.push_back(write);
        reqs_sent++;
        if ((reqs_sent - credits_back) > max_outstanding) begin
            max_outstanding = reqs_sent - credits_back;
        end
        drive_quiet();
        ss_req_valid = 1'b1;
        ss_req_write = write;
        ss_req_addr  = POOL_BASE + ADDR_WIDTH'(idx);
        ss_req_data  = bus;
        next_cycle();
    endtask

    task automatic drain_ss();
        while (credits_back != reqs_sent) begin
            idle_cycle();
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        idx_t           idx;
        ram_pkg::word_t wdata;
        logic [1:0]     lanes_n;
        logic           write;
        rst          = 1'b1;
        address      = '0;
        data         = '0;
        we_uds_n     = 1'b1;
        we_lds_n     = 1'b1;
        ss_req_valid = 1'b0;
        ss_req_write = 1'b0;
        ss_req_addr  = '0;
        ss_req_data  = '0;
        // q clears under reset
        next_exp_q   = '0;
        next_chk_q   = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst = 1'b0;
        repeat (4) idle_cycle();

        test_name = "cpu_full_write";
        for (int i = 0; i < POOL_SIZE; i++) begin
            wdata = ram_pkg::word_t'($random(seed));
            cpu_write(idx_t'(i), wdata, 1'b0, 1'b0);
        end
        settle();

        test_name = "cpu_lane_write";
        for (int i = 0; i < 64; i++) begin
            idx     = idx_t'($random(seed));
            wdata   = ram_pkg::word_t'($random(seed));
            lanes_n = 2'($random(seed));
            cpu_write(idx, wdata, lanes_n[1], lanes_n[0]);
        end
        settle();
        test_name = "cpu_readback";
        read_all();
        settle();

        test_name = "ss_write";
        for (int i = 0; i < 16; i++) begin
            idx   = idx_t'($random(seed));
            wdata = ram_pkg::word_t'($random(seed));
            ss_send(1'b1, idx, wdata);
        end
        drain_ss();
        settle();
        test_name = "ss_write_readback";
        read_all();
        settle();

        // Most of these words came from CPU writes
        test_name = "ss_read";
        for (int i = 0; i < POOL_SIZE; i++) begin
            ss_send(1'b0, idx_t'(i), '0);
        end
        drain_ss();
        settle();

        test_name = "ss_mixed";
        for (int i = 0; i < 40; i++) begin
            write = 1'($random(seed));
            idx   = idx_t'($random(seed));
            wdata = ram_pkg::word_t'($random(seed));
            ss_send(write, idx, wdata);
        end
        drain_ss();
        settle();
        test_name = "final_readback";
        read_all();
        settle();

        test_name = "credits";
        assert (credits_back == reqs_sent)
            else value_error(test_name, ram_pkg::ss_data_t'(reqs_sent),
                             ram_pkg::ss_data_t'(credits_back));
        assert (max_outstanding == SS_CREDITS)
            else value_error(test_name, ram_pkg::ss_data_t'(SS_CREDITS),
                             ram_pkg::ss_data_t'(max_outstanding));
        assert (rsp_data_q.size() == 0)
            else flow_error("Some save-state responses never arrived");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
hdl/ram_pkg.sv
hdl/ss_request_decode.sv
hdl/byte_lane_ram.sv
hdl/ss_response.sv
hdl/m68k_state_ram.sv
test/tb_m68k_state_ram.sv

//--- Makefile
TOP = tb_m68k_state_ram

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
